/* files.f */
link_pkg.sv
cfg_pkg.sv
ll_auto_sync.sv
lpif_phy_concat.sv
lpif_apb_regs.sv
lpif_link_master_top.sv
tb_clkgen.sv
lpif_link_props.sv
tb_lpif_link.sv

/* run.sh */
#!/bin/sh
# Build and run the LPIF link testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_lpif_link -f files.f -o sim_lpif_link
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_lpif_link)
rc=$?
printf '%s\n' "$out"
if [ $rc -ne 0 ]; then
  echo "Simulation exited with status $rc"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx 'STATUS: PASS'; then
  exit 0
fi
echo "Pass message not found"
exit 1

/* tb_lpif_link.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_lpif_link
  import link_pkg::*;
  import cfg_pkg::*;
();

  localparam int CLK_NS     = 8;
  localparam int RST_CYCLES = 5;
  localparam int DELAY_W    = 16;
  // Sample point inside the low clock phase
  localparam int SAMPLE_NS  = 2;
  localparam int POLL_MAX   = 64;
  localparam int SETUP_CYC  = 200;
  localparam logic [31:0] DLY_MASK = 32'((64'd1 << DELAY_W) - 1);
  // Link bring-up values
  localparam int DLY_X = 3;
  localparam int DLY_Y = 5;
  localparam int DLY_Z = 2;
  localparam logic [1:0] BASE_CTRL = 2'b11;

  typedef struct packed {
    logic [3:0] state;
    logic [1:0] protid;
    logic       valid;
    logic [1:0] ctrl;
  } row_t;

  localparam int ROWS = 12;
  localparam int WATCHDOG_NS = (ROWS + SETUP_CYC) * CLK_NS;

  // Columns are state, protid, valid, REG_CTRL value written during the row
  // No two neighbouring rows change REG_CTRL, row 0 keeps BASE_CTRL
  localparam logic [8:0] TBL [ROWS] = '{
    {4'h1, 2'd0, 1'b1, 2'b11}, {4'h2, 2'd1, 1'b1, 2'b11}, {4'h3, 2'd2, 1'b0, 2'b01},
    {4'h4, 2'd3, 1'b1, 2'b01}, {4'h5, 2'd0, 1'b1, 2'b01}, {4'h6, 2'd1, 1'b0, 2'b10},
    {4'h7, 2'd2, 1'b1, 2'b10}, {4'h8, 2'd3, 1'b1, 2'b00}, {4'h9, 2'd0, 1'b0, 2'b00},
    {4'hA, 2'd1, 1'b1, 2'b10}, {4'hB, 2'd2, 1'b1, 2'b10}, {4'hC, 2'd3, 1'b1, 2'b10}
  };

  logic             clk;
  logic             rst_n;
  logic             tx_online;
  logic             rx_online;
  lpif_flit_t       dstrm;
  lpif_flit_t       ustrm;
  logic [PHY_W-1:0] tx_phy0;
  logic [PHY_W-1:0] rx_phy0;
  apb_req_t         apb_req;
  apb_rsp_t         apb_rsp;

  int               errors;
  int               checks;
  logic [15:0]      lfsr;
  lpif_flit_t       exp_flit [ROWS];
  logic [1:0]       ctrl_col [ROWS];
  lpif_flit_t       idle_flit;

  // PHY lane looped straight back
  assign rx_phy0 = tx_phy0;

  tb_clkgen #(
    .CLK_NS     (CLK_NS),
    .RST_CYCLES (RST_CYCLES)
  ) u_clkgen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  lpif_link_master_top #(
    .DELAY_W (DELAY_W)
  ) DUT (
    .clk_wr    (clk),
    .rst_n     (rst_n),
    .tx_online (tx_online),
    .rx_online (rx_online),
    .dstrm     (dstrm),
    .ustrm     (ustrm),
    .tx_phy0   (tx_phy0),
    .rx_phy0   (rx_phy0),
    .apb_req   (apb_req),
    .apb_rsp   (apb_rsp)
  );

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  task automatic check_val(input string name, input logic [79:0] exp, input logic [79:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("[FAIL] %s expected 0x%0h actual 0x%0h", name, exp, act);
    end
  endtask

  task automatic report_error(input string what);
    errors++;
    $display("ERROR: %s", what);
  endtask

  // Galois LFSR, taps 16,14,13,11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // One LFSR step for every bit taken
  task automatic take_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[62:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  // Called on a falling edge, returns on a falling edge
  task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err);
    apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
    @(negedge clk);
    apb_req.penable = 1'b1;
    #(SAMPLE_NS);
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    @(negedge clk);
    apb_req = '0;
  endtask

  task automatic read_expect(input logic [7:0] addr, input logic [31:0] exp_data,
                             input logic exp_err, input string name);
    logic [31:0] d;
    logic        e;
    apb_xfer(1'b0, addr, 32'h0, d, e);
    check_val({name, " prdata"}, exp_data, d);
    check_val({name, " pslverr"}, exp_err, e);
  endtask

  task automatic write_expect(input logic [7:0] addr, input logic [31:0] data,
                              input logic exp_err, input string name);
    logic [31:0] d;
    logic        e;
    apb_xfer(1'b1, addr, data, d, e);
    check_val({name, " write pslverr"}, exp_err, e);
  endtask

  // Write then read back the implemented low bits
  task automatic rw_check(input logic [7:0] addr, input logic [31:0] data,
                          input logic [31:0] mask, input string name);
    write_expect(addr, data, 1'b0, name);
    read_expect(addr, data & mask, 1'b0, name);
  endtask

  ////////////////////////////////////////
  // Watchdog
  ////////////////////////////////////////

  initial begin
    #(WATCHDOG_NS);
    report_error($sformatf("run did not finish within %0d ns", WATCHDOG_NS));
    $display("checks=%0d errors=%0d", checks, errors);
    $display("STATUS: FAIL");
    $finish;
  end

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    logic [63:0]      bits;
    int               edges;
    int               n_valid;
    row_t             row;
    logic [1:0]       ctrl_now;
    logic [PHY_W-1:0] exp_word;
    errors    = 0;
    checks    = 0;
    lfsr      = 16'd82;
    tx_online = 1'b0;
    rx_online = 1'b0;
    dstrm     = '0;
    apb_req   = '0;
    idle_flit = '0;
    idle_flit.state = 4'hF;
    @(posedge rst_n);

    // Reset values, read back, error responses
    read_expect(REG_CTRL, 32'd0, 1'b0, "ctrl reset");
    read_expect(REG_DLY_X, 32'd4, 1'b0, "dly_x reset");
    read_expect(REG_DLY_Y, 32'd4, 1'b0, "dly_y reset");
    read_expect(REG_DLY_Z, 32'd2, 1'b0, "dly_z reset");
    read_expect(REG_STATUS, 32'd0, 1'b0, "status reset");
    rw_check(REG_DLY_X, 32'h5A5A_1234, DLY_MASK, "dly_x");
    rw_check(REG_DLY_Y, 32'hFFFF_00C3, DLY_MASK, "dly_y");
    rw_check(REG_DLY_Z, 32'h0001_0007, DLY_MASK, "dly_z");
    rw_check(REG_CTRL, 32'hFFFF_FFFE, 32'h3, "ctrl");
    read_expect(8'h14, 32'd0, 1'b1, "unmapped");
    write_expect(REG_STATUS, 32'hFFFF_FFFF, 1'b1, "status");
    read_expect(REG_STATUS, 32'd0, 1'b0, "status after write");

    write_expect(REG_DLY_X, DLY_X, 1'b0, "dly_x");
    write_expect(REG_DLY_Y, DLY_Y, 1'b0, "dly_y");
    write_expect(REG_DLY_Z, DLY_Z, 1'b0, "dly_z");
    write_expect(REG_CTRL, 32'(BASE_CTRL), 1'b0, "ctrl");

    // Tx bring-up, first sampling edge plus delay X plus the word register
    dstrm     = idle_flit;
    tx_online = 1'b1;
    edges     = 0;
    while (!tx_phy0[ONL_BIT] && edges < POLL_MAX) begin
      check_val("tx_phy0 offline", '0, tx_phy0);
      @(posedge clk);
      edges++;
      @(negedge clk);
    end
    if (edges >= POLL_MAX) report_error("tx_phy0 never showed the online bit");
    check_val("tx online edges", 1 + DLY_X + 1, edges);

    // User bits held low for delay Z words
    for (int i = 0; i <= DLY_Z; i++) begin
      if (i > 0) @(negedge clk);
      ctrl_now = (i < DLY_Z) ? 2'b00 : BASE_CTRL;
      check_val("tx_phy0 user bits", {1'b1, ctrl_now[1], ctrl_now[0], idle_flit}, tx_phy0);
    end

    // Rx bring-up, seen on ustrm one edge after the flag
    rx_online = 1'b1;
    edges     = 0;
    while (ustrm == '0 && edges < POLL_MAX) begin
      @(posedge clk);
      edges++;
      @(negedge clk);
    end
    if (edges >= POLL_MAX) report_error("ustrm never carried a flit after rx online");
    check_val("rx online edges", 1 + DLY_Y + 1, edges);
    check_val("ustrm idle flit", idle_flit, ustrm);
    read_expect(REG_STATUS, 32'h0000_0003, 1'b0, "status online");

    // Expected flits, data and crc from the LFSR
    n_valid = 0;
    for (int r = 0; r < ROWS; r++) begin
      row = row_t'(TBL[r]);
      ctrl_col[r] = row.ctrl;
      n_valid += row.valid;
      take_bits(64, bits);
      exp_flit[r]        = '0;
      exp_flit[r].state  = row.state;
      exp_flit[r].protid = row.protid;
      exp_flit[r].data   = bits;
      exp_flit[r].dvalid = row.valid;
      take_bits(4, bits);
      exp_flit[r].crc       = bits[3:0];
      exp_flit[r].crc_valid = row.valid;
      exp_flit[r].valid     = row.valid;
    end

    // Streaming, tx word one edge and ustrm two edges after driving
    for (int k = 0; k < ROWS + 2; k++) begin
      if (k >= 1 && k - 1 < ROWS) begin
        // Each word carries the control value in force before its row
        ctrl_now = (k == 1) ? BASE_CTRL : ctrl_col[k-2];
        exp_word = {1'b1, ctrl_now[1], ctrl_now[0], exp_flit[k-1]};
        check_val($sformatf("tx_phy0 row %0d", k - 1), exp_word, tx_phy0);
      end
      if (k >= 2) check_val($sformatf("ustrm row %0d", k - 2), exp_flit[k-2], ustrm);
      dstrm   = (k < ROWS) ? exp_flit[k] : '0;
      apb_req = '0;
      // Setup one row early, access during the row that changes REG_CTRL
      if (k + 1 < ROWS && ctrl_col[k+1] != ctrl_col[k]) begin
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: REG_CTRL,
                    pwdata: 32'(ctrl_col[k+1])};
      end
      if (k > 0 && k < ROWS && ctrl_col[k] != ctrl_col[k-1]) begin
        apb_req = '{psel: 1'b1, penable: 1'b1, pwrite: 1'b1, paddr: REG_CTRL,
                    pwdata: 32'(ctrl_col[k])};
      end
      @(negedge clk);
    end
    apb_req = '0;
    read_expect(REG_STATUS, {n_valid[15:0], 14'h0, 2'b11}, 1'b0, "status count");

    // Rx offline, flits blocked and count frozen
    rx_online = 1'b0;
    dstrm     = exp_flit[0];
    repeat (4) begin
      @(negedge clk);
      check_val("ustrm rx offline", '0, ustrm);
    end
    dstrm = '0;
    read_expect(REG_STATUS, {n_valid[15:0], 14'h0, 2'b01}, 1'b0, "status rx offline");

    errors += int'(DUT.u_props.fails);
    $display("checks=%0d errors=%0d assertion_fails=%0d", checks, errors, DUT.u_props.fails);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule : tb_lpif_link

`default_nettype wire

/* lpif_link_props.sv */
`timescale 1ns/1ps
`default_nettype none

module lpif_link_props
  import link_pkg::*;
  import cfg_pkg::*;
(
  input logic             clk_wr,
  input logic             rst_n,
  input logic             tx_online_delay,
  input logic             rx_online_delay,
  input logic [PHY_W-1:0] tx_phy0,
  input lpif_flit_t       ustrm,
  input apb_rsp_t         apb_rsp
);

  // Failed assertions, summed into the testbench error count
  int unsigned fails = 0;

  // Word registered one cycle after the flag, so look one edge ahead
  a_tx_quiet: assert property (@(posedge clk_wr) disable iff (!rst_n)
    !tx_online_delay |=> (tx_phy0 == '0))
  else begin
    fails++;
    $error("tx_phy0 carries data while tx_online_delay is low");
  end

  // No wait states on the register bus
  a_pready: assert property (@(posedge clk_wr) disable iff (!rst_n)
    apb_rsp.pready)
  else begin
    fails++;
    $error("pready dropped low");
  end

  // Rx side offline, nothing valid reaches the user channel
  a_rx_quiet: assert property (@(posedge clk_wr) disable iff (!rst_n)
    !rx_online_delay |=> !ustrm.valid)
  else begin
    fails++;
    $error("ustrm valid while rx_online_delay is low");
  end

endmodule : lpif_link_props

bind lpif_link_master_top lpif_link_props u_props (
  .clk_wr          (clk_wr),
  .rst_n           (rst_n),
  .tx_online_delay (tx_online_delay),
  .rx_online_delay (rx_online_delay),
  .tx_phy0         (tx_phy0),
  .ustrm           (ustrm),
  .apb_rsp         (apb_rsp)
);

`default_nettype wire

/* tb_clkgen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
  parameter int CLK_NS     = 8,
  parameter int RST_CYCLES = 5
) (
  output logic clk,
  output logic rst_n
);

  // Free running clock, low at time zero
  initial clk = 1'b0;
  always #(CLK_NS / 2) clk = ~clk;

  // Reset held for a fixed number of rising edges, released on a falling edge
  initial begin
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule : tb_clkgen

`default_nettype wire

/* lpif_link_master_top.sv */
`timescale 1ns/1ps
`default_nettype none

module lpif_link_master_top
  import link_pkg::*;
  import cfg_pkg::*;
#(
  parameter int DELAY_W = 16
) (
  input  logic             clk_wr,
  input  logic             rst_n,
  input  logic             tx_online,
  input  logic             rx_online,
  // User channel
  input  lpif_flit_t       dstrm,
  output lpif_flit_t       ustrm,
  // Single PHY lane
  output logic [PHY_W-1:0] tx_phy0,
  input  logic [PHY_W-1:0] rx_phy0,
  // Register access
  input  apb_req_t         apb_req,
  output apb_rsp_t         apb_rsp
);

  ////////////////////////////////////////
  // Interconnect
  ////////////////////////////////////////

  sync_cfg_t   sync_cfg;
  logic        tx_online_delay;
  logic        rx_online_delay;
  logic        tx_auto_mrk_userbit;
  logic        tx_auto_stb_userbit;
  logic [15:0] rx_flit_count;

  // Config and status
  lpif_apb_regs #(
    .DELAY_W (DELAY_W)
  ) u_regs (
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .apb_req         (apb_req),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .rx_flit_count   (rx_flit_count),
    .apb_rsp         (apb_rsp),
    .sync_cfg        (sync_cfg)
  );

  // Online delays and user bits
  ll_auto_sync #(
    .DELAY_W (DELAY_W)
  ) u_sync (
    .clk_wr              (clk_wr),
    .rst_n               (rst_n),
    .tx_online           (tx_online),
    .rx_online           (rx_online),
    .sync_cfg            (sync_cfg),
    .tx_online_delay     (tx_online_delay),
    .rx_online_delay     (rx_online_delay),
    .tx_auto_mrk_userbit (tx_auto_mrk_userbit),
    .tx_auto_stb_userbit (tx_auto_stb_userbit)
  );

  // Flit to PHY word and back
  lpif_phy_concat u_concat (
    .clk_wr              (clk_wr),
    .rst_n               (rst_n),
    .dstrm               (dstrm),
    .rx_phy0             (rx_phy0),
    .tx_online_delay     (tx_online_delay),
    .rx_online_delay     (rx_online_delay),
    .tx_auto_mrk_userbit (tx_auto_mrk_userbit),
    .tx_auto_stb_userbit (tx_auto_stb_userbit),
    .tx_phy0             (tx_phy0),
    .ustrm               (ustrm),
    .rx_flit_count       (rx_flit_count)
  );

endmodule : lpif_link_master_top

`default_nettype wire

/* lpif_apb_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module lpif_apb_regs
  import cfg_pkg::*;
#(
  parameter int DELAY_W = 16
) (
  input  logic        clk_wr,
  input  logic        rst_n,
  input  apb_req_t    apb_req,
  input  logic        tx_online_delay,
  input  logic        rx_online_delay,
  input  logic [15:0] rx_flit_count,
  output apb_rsp_t    apb_rsp,
  output sync_cfg_t   sync_cfg
);

  // Configuration registers
  logic [DELAY_W-1:0] dly_x_q;
  logic [DELAY_W-1:0] dly_y_q;
  logic [DELAY_W-1:0] dly_z_q;
  logic [1:0]         ctrl_q;

  // Decode
  logic               access;
  logic               addr_hit;
  logic               wr_ro;
  logic               wr_en;
  logic [31:0]        rd_data;

  // Access phase of a transfer
  assign access = apb_req.psel & apb_req.penable;

  ////////////////////////////////////////
  // Address decode and read mux
  ////////////////////////////////////////

  always_comb begin
    addr_hit = 1'b1;
    rd_data  = '0;
    case (apb_req.paddr)
      REG_CTRL:   rd_data = 32'(ctrl_q);
      REG_DLY_X:  rd_data = 32'(dly_x_q);
      REG_DLY_Y:  rd_data = 32'(dly_y_q);
      REG_DLY_Z:  rd_data = 32'(dly_z_q);
      // Count on top, tx flag bit 0, rx flag bit 1
      REG_STATUS: rd_data = {rx_flit_count, 14'h0, rx_online_delay, tx_online_delay};
      default:    addr_hit = 1'b0;
    endcase
  end

  // Status is read only
  assign wr_ro = apb_req.pwrite && (apb_req.paddr == REG_STATUS);
  assign wr_en = access && apb_req.pwrite && addr_hit && !wr_ro;

  ////////////////////////////////////////
  // Register writes
  ////////////////////////////////////////

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      dly_x_q <= RST_DLY_X[DELAY_W-1:0];
      dly_y_q <= RST_DLY_Y[DELAY_W-1:0];
      dly_z_q <= RST_DLY_Z[DELAY_W-1:0];
      ctrl_q  <= RST_CTRL;
    end else if (wr_en) begin
      case (apb_req.paddr)
        REG_CTRL:  ctrl_q  <= apb_req.pwdata[1:0];
        REG_DLY_X: dly_x_q <= apb_req.pwdata[DELAY_W-1:0];
        REG_DLY_Y: dly_y_q <= apb_req.pwdata[DELAY_W-1:0];
        REG_DLY_Z: dly_z_q <= apb_req.pwdata[DELAY_W-1:0];
        default:   ;
      endcase
    end
  end

  ////////////////////////////////////////
  // Response
  ////////////////////////////////////////

  // No wait states
  always_comb begin
    apb_rsp.pready  = 1'b1;
    apb_rsp.pslverr = access && (!addr_hit || wr_ro);
    // Zero on failed reads and on writes
    apb_rsp.prdata  = (apb_req.psel && !apb_req.pwrite && addr_hit) ? rd_data : '0;
  end

  // Config to the synchronizer
  always_comb begin
    sync_cfg.delay_x     = 16'(dly_x_q);
    sync_cfg.delay_y     = 16'(dly_y_q);
    sync_cfg.delay_z     = 16'(dly_z_q);
    sync_cfg.mrk_userbit = ctrl_q[CTRL_MRK_BIT];
    sync_cfg.stb_userbit = ctrl_q[CTRL_STB_BIT];
  end

endmodule : lpif_apb_regs

`default_nettype wire

/* lpif_phy_concat.sv */
`timescale 1ns/1ps
`default_nettype none

module lpif_phy_concat
  import link_pkg::*;
(
  input  logic             clk_wr,
  input  logic             rst_n,
  input  lpif_flit_t       dstrm,
  input  logic [PHY_W-1:0] rx_phy0,
  input  logic             tx_online_delay,
  input  logic             rx_online_delay,
  input  logic             tx_auto_mrk_userbit,
  input  logic             tx_auto_stb_userbit,
  output logic [PHY_W-1:0] tx_phy0,
  output lpif_flit_t       ustrm,
  output logic [15:0]      rx_flit_count
);

  // Next outgoing PHY word
  logic [PHY_W-1:0] tx_word;
  // Flit field of the incoming word
  lpif_flit_t       rx_flit;
  // Incoming word is live
  logic             rx_accept;

  ////////////////////////////////////////
  // Tx packing
  ////////////////////////////////////////

  // Word stays all zero until the link is online
  always_comb begin
    tx_word = '0;
    if (tx_online_delay) begin
      tx_word[FLIT_W-1:0] = dstrm;
      tx_word[MRK_BIT]    = tx_auto_mrk_userbit;
      tx_word[STB_BIT]    = tx_auto_stb_userbit;
      // Far end uses this to qualify the word
      tx_word[ONL_BIT]    = tx_online_delay;
    end
  end

  // One register stage toward the lane
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      tx_phy0 <= '0;
    end else begin
      tx_phy0 <= tx_word;
    end
  end

  ////////////////////////////////////////
  // Rx unpacking
  ////////////////////////////////////////

  assign rx_flit   = lpif_flit_t'(rx_phy0[FLIT_W-1:0]);
  // Local rx side up and remote marks its word online
  assign rx_accept = rx_online_delay & rx_phy0[ONL_BIT];

  // Marker and strobe bits are sideband only and dropped here
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      ustrm <= '0;
    end else if (rx_accept) begin
      ustrm <= rx_flit;
    end else begin
      ustrm <= '0;
    end
  end

  // Valid flits accepted, wraps at 16 bits
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      rx_flit_count <= '0;
    end else if (rx_accept && rx_flit.valid) begin
      rx_flit_count <= rx_flit_count + 16'd1;
    end
  end

endmodule : lpif_phy_concat

`default_nettype wire

/* ll_auto_sync.sv */
`timescale 1ns/1ps
`default_nettype none

module ll_auto_sync
  import cfg_pkg::*;
#(
  parameter int DELAY_W = 16
) (
  input  logic      clk_wr,
  input  logic      rst_n,
  input  logic      tx_online,
  input  logic      rx_online,
  input  sync_cfg_t sync_cfg,
  output logic      tx_online_delay,
  output logic      rx_online_delay,
  output logic      tx_auto_mrk_userbit,
  output logic      tx_auto_stb_userbit
);

  // Effective delays, zero treated as one
  logic [DELAY_W-1:0] dly_x_eff;
  logic [DELAY_W-1:0] dly_y_eff;
  logic [DELAY_W-1:0] dly_z_eff;

  // Saturating cycle counters
  logic [DELAY_W-1:0] tx_cnt;
  logic [DELAY_W-1:0] rx_cnt;
  logic [DELAY_W-1:0] usr_cnt;

  // User bits released
  logic               usr_en;

  assign dly_x_eff = (sync_cfg.delay_x[DELAY_W-1:0] == '0) ? DELAY_W'(1)
                                                           : sync_cfg.delay_x[DELAY_W-1:0];
  assign dly_y_eff = (sync_cfg.delay_y[DELAY_W-1:0] == '0) ? DELAY_W'(1)
                                                           : sync_cfg.delay_y[DELAY_W-1:0];
  assign dly_z_eff = (sync_cfg.delay_z[DELAY_W-1:0] == '0) ? DELAY_W'(1)
                                                           : sync_cfg.delay_z[DELAY_W-1:0];

  ////////////////////////////////////////
  // Tx online delay
  ////////////////////////////////////////

  // Counter holds the number of edges already seen with tx_online high
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      tx_cnt          <= '0;
      tx_online_delay <= 1'b0;
    end else if (!tx_online) begin
      tx_cnt          <= '0;
      tx_online_delay <= 1'b0;
    end else begin
      if (tx_cnt < dly_x_eff) begin
        tx_cnt <= tx_cnt + 1'b1;
      end
      // Rises on the edge delay_x after the first high sample
      tx_online_delay <= (tx_cnt >= dly_x_eff);
    end
  end

  ////////////////////////////////////////
  // Rx online delay
  ////////////////////////////////////////

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      rx_cnt          <= '0;
      rx_online_delay <= 1'b0;
    end else if (!rx_online) begin
      rx_cnt          <= '0;
      rx_online_delay <= 1'b0;
    end else begin
      if (rx_cnt < dly_y_eff) begin
        rx_cnt <= rx_cnt + 1'b1;
      end
      rx_online_delay <= (rx_cnt >= dly_y_eff);
    end
  end

  ////////////////////////////////////////
  // User bit enable
  ////////////////////////////////////////

  // Starts counting the edge after tx_online_delay rises
  // Raw tx_online in the clear term so a drop kills the bits at once
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      usr_cnt <= '0;
      usr_en  <= 1'b0;
    end else if (!tx_online || !tx_online_delay) begin
      usr_cnt <= '0;
      usr_en  <= 1'b0;
    end else begin
      if (usr_cnt < dly_z_eff) begin
        usr_cnt <= usr_cnt + 1'b1;
      end
      // Count already one behind, compare against delay_z minus one
      usr_en <= (usr_cnt >= dly_z_eff - 1'b1);
    end
  end

  // Control bits pass straight through once enabled
  assign tx_auto_mrk_userbit = usr_en & sync_cfg.mrk_userbit;
  assign tx_auto_stb_userbit = usr_en & sync_cfg.stb_userbit;

endmodule : ll_auto_sync

`default_nettype wire

/* cfg_pkg.sv */
`default_nettype none

package cfg_pkg;

  ////////////////////////////////////////
  // APB bus
  ////////////////////////////////////////

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  // Register map
  localparam logic [7:0] REG_CTRL   = 8'h00;
  localparam logic [7:0] REG_DLY_X  = 8'h04;
  localparam logic [7:0] REG_DLY_Y  = 8'h08;
  localparam logic [7:0] REG_DLY_Z  = 8'h0C;
  localparam logic [7:0] REG_STATUS = 8'h10;

  // REG_CTRL bit positions
  localparam int CTRL_MRK_BIT = 0;
  localparam int CTRL_STB_BIT = 1;

  // Values after reset
  localparam logic [15:0] RST_DLY_X = 16'd4;
  localparam logic [15:0] RST_DLY_Y = 16'd4;
  localparam logic [15:0] RST_DLY_Z = 16'd2;
  localparam logic [1:0]  RST_CTRL  = 2'b00;

  ////////////////////////////////////////
  // Synchronizer configuration
  ////////////////////////////////////////

  typedef struct packed {
    logic [15:0] delay_x;
    logic [15:0] delay_y;
    logic [15:0] delay_z;
    logic        mrk_userbit;
    logic        stb_userbit;
  } sync_cfg_t;

endpackage : cfg_pkg

`default_nettype wire

/* link_pkg.sv */
`default_nettype none

package link_pkg;

  ////////////////////////////////////////
  // Flit carried on the user channel
  ////////////////////////////////////////

  // Field order matches the LPIF channel, state in the top bits
  typedef struct packed {
    logic [3:0]  state;
    logic [1:0]  protid;
    logic [63:0] data;
    logic        dvalid;
    logic [3:0]  crc;
    logic        crc_valid;
    logic        valid;
  } lpif_flit_t;

  ////////////////////////////////////////
  // PHY word layout
  ////////////////////////////////////////

  // Flit sits at bit 0 upward
  localparam int FLIT_W  = $bits(lpif_flit_t);
  localparam int PHY_W   = 80;
  // Sideband bits above the flit
  localparam int MRK_BIT = 77;
  localparam int STB_BIT = 78;
  localparam int ONL_BIT = 79;

endpackage : link_pkg

`default_nettype wire
